// ==== flist.f ====
verilog/smc_bus_pkg.sv
verilog/smc_mem_pkg.sv
verilog/smc_req_if.sv
verilog/smc_req_queue.sv
verilog/smc_access_ctrl.sv
verilog/smc_wr_enable.sv
verilog/smc_top.sv
test/sram_model.sv
test/smc_tb.sv

// ==== test/smc_tb.sv ====
// testbench for the static memory controller
// requests come from a table, issued only while a credit is held
// rising-edge outputs checked at the falling edge, strobes at the rising
// stops at the first mismatch
`default_nettype none

module smc_tb;

  import smc_bus_pkg::*;
  import smc_mem_pkg::*;

  localparam int NUM_VEC    = 12;
  localparam int RESET_CYC  = 5;
  localparam int MAX_CYCLES = NUM_VEC * (ACCESS_CYC + 1) + 50;

  typedef logic [CREDIT_W-1:0] credit_t;

  // one table row
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t data;
    be_t   be;
    data_t exp;
  } vec_t;

  logic   hclk;
  logic   arst_n;
  logic   req_valid;
  logic   req_write;
  addr_t  req_addr;
  data_t  req_wdata;
  be_t    req_be;
  logic   credit_return;
  logic   resp_valid;
  data_t  resp_rdata;
  addr_t  mem_addr;
  data_t  mem_wdata;
  data_t  mem_rdata;
  logic   mem_n_cs;
  logic   mem_n_oe;
  lane_t  mem_n_we;
  logic   mem_n_wr;

  vec_t    vecs [NUM_VEC];
  string   vec_names [NUM_VEC];
  // table rows of reads and writes still in flight
  int      rd_q [$];
  int      wr_q [$];
  credit_t credits;
  credit_t min_credits;
  int      idx;
  int      cycles;
  int      seed;
  logic    wr_seen;

  smc_top UUT (
    .hclk          (hclk),
    .arst_n        (arst_n),
    .req_valid     (req_valid),
    .req_write     (req_write),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .req_be        (req_be),
    .credit_return (credit_return),
    .resp_valid    (resp_valid),
    .resp_rdata    (resp_rdata),
    .mem_addr      (mem_addr),
    .mem_wdata     (mem_wdata),
    .mem_rdata     (mem_rdata),
    .mem_n_cs      (mem_n_cs),
    .mem_n_oe      (mem_n_oe),
    .mem_n_we      (mem_n_we),
    .mem_n_wr      (mem_n_wr)
  );

  sram_model u_sram (
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata),
    .n_cs  (mem_n_cs),
    .n_oe  (mem_n_oe),
    .n_we  (mem_n_we)
  );

  // --------------------
  // checks
  // --------------------
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp)
      stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp)
      stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_lane(input string name, input lane_t exp, input lane_t act);
    if (act !== exp)
      stop_on_error($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_credit(input string name, input credit_t exp, input credit_t act);
    if (act !== exp)
      stop_on_error($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      stop_on_error($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
  endtask

  // all strobes inactive, nothing returned
  // falling-edge strobes looked at on the next rising edge
  task automatic check_idle_pins(input string name);
    check_bit({name, " n_cs"}, 1'b1, mem_n_cs);
    check_bit({name, " n_oe"}, 1'b1, mem_n_oe);
    check_bit({name, " credit_return"}, 1'b0, credit_return);
    check_bit({name, " resp_valid"}, 1'b0, resp_valid);
    @(posedge hclk);
    check_lane({name, " n_we"}, '1, mem_n_we);
    check_bit({name, " n_wr"}, 1'b1, mem_n_wr);
  endtask

  // --------------------
  // stimulus table
  // --------------------
  task automatic set_vec(input int i, input string name, input logic write,
                         input addr_t addr, input data_t data, input be_t be,
                         input data_t exp);
    vecs[i]      = '{write: write, addr: addr, data: data, be: be, exp: exp};
    vec_names[i] = name;
  endtask

  task automatic build_table();
    data_t fill_a;
    data_t fill_b;
    fill_a = $random(seed);
    fill_b = $random(seed);
    // first rows go out back to back and drain the credits
    set_vec(0,  "fill a write",    1'b1, 14'h0123, fill_a,       4'b1111, '0);
    set_vec(1,  "fill a read",     1'b0, 14'h0123, '0,           4'b0000, fill_a);
    set_vec(2,  "full write",      1'b1, 14'h0010, 32'h11223344, 4'b1111, '0);
    set_vec(3,  "lanes 0 2 write", 1'b1, 14'h0010, 32'haabbccdd, 4'b0101, '0);
    set_vec(4,  "merge read",      1'b0, 14'h0010, '0,           4'b0000, 32'h11bb33dd);
    set_vec(5,  "top full write",  1'b1, 14'h3fff, 32'hcafef00d, 4'b1111, '0);
    set_vec(6,  "top lane 3",      1'b1, 14'h3fff, 32'h5a000000, 4'b1000, '0);
    set_vec(7,  "top read",        1'b0, 14'h3fff, '0,           4'b0000, 32'h5afef00d);
    set_vec(8,  "fill b write",    1'b1, 14'h2a5c, fill_b,       4'b1111, '0);
    set_vec(9,  "fill b read",     1'b0, 14'h2a5c, '0,           4'b0000, fill_b);
    set_vec(10, "merge reread",    1'b0, 14'h0010, '0,           4'b0000, 32'h11bb33dd);
    set_vec(11, "fill a reread",   1'b0, 14'h0123, '0,           4'b0000, fill_a);
  endtask

  // one cycle, then credits and read responses
  task automatic step_cycle();
    @(negedge hclk);
    if (credit_return)
    begin
      if (credits == credit_t'(QUEUE_DEPTH))
        stop_on_error("credit_return pulsed with no credit outstanding");
      else
        credits = credits + 1'b1;
    end
    if (resp_valid)
    begin
      if (rd_q.size() == 0)
        stop_on_error("read response arrived with no read outstanding");
      else
      begin
        check_data(vec_names[rd_q[0]], vecs[rd_q[0]].exp, resp_rdata);
        void'(rd_q.pop_front());
      end
    end
  endtask

  initial
  begin
    hclk = 1'b0;
    forever #5 hclk = ~hclk;
  end

  // strobe pins change on the falling edge, look at them on the rising
  always @(posedge hclk)
  begin
    if (arst_n)
    begin
      if (!mem_n_wr)
      begin
        if (wr_q.size() == 0)
          stop_on_error("write strobe seen with no write outstanding");
        else
        begin
          check_bit({vec_names[wr_q[0]], " n_cs"}, 1'b0, mem_n_cs);
          check_bit({vec_names[wr_q[0]], " n_oe"}, 1'b1, mem_n_oe);
          check_addr({vec_names[wr_q[0]], " addr"}, vecs[wr_q[0]].addr, mem_addr);
          check_data({vec_names[wr_q[0]], " wdata"}, vecs[wr_q[0]].data, mem_wdata);
          check_lane({vec_names[wr_q[0]], " n_we"}, lane_t'(~vecs[wr_q[0]].be), mem_n_we);
          wr_seen = 1'b1;
        end
      end
      else
      begin
        // no lane low outside a write strobe, reads included
        check_lane("n_we outside strobe", '1, mem_n_we);
        if (wr_seen)
          void'(wr_q.pop_front());
        wr_seen = 1'b0;
      end
    end
  end

  // watchdog
  always @(posedge hclk)
  begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES)
      stop_on_error($sformatf("timeout, run still busy after %0d cycles", MAX_CYCLES));
  end

  // --------------------
  // main sequence
  // --------------------
  initial
  begin
    seed        = 32'h9ae2a194;
    arst_n      = 1'b0;
    req_valid   = 1'b0;
    req_write   = 1'b0;
    req_addr    = '0;
    req_wdata   = '0;
    req_be      = '0;
    cycles      = 0;
    wr_seen     = 1'b0;
    credits     = credit_t'(QUEUE_DEPTH);
    min_credits = credit_t'(QUEUE_DEPTH);
    build_table();
    repeat (RESET_CYC - 1)
    begin
      step_cycle();
      check_idle_pins("in reset");
    end
    // release on the last falling edge of reset
    step_cycle();
    arst_n = 1'b1;
    repeat (3)
    begin
      step_cycle();
      check_idle_pins("after reset");
    end
    idx = 0;
    while (idx < NUM_VEC)
    begin
      step_cycle();
      if (credits != '0)
      begin
        req_valid   = 1'b1;
        req_write   = vecs[idx].write;
        req_addr    = vecs[idx].addr;
        req_wdata   = vecs[idx].data;
        req_be      = vecs[idx].be;
        credits     = credits - 1'b1;
        if (credits < min_credits)
          min_credits = credits;
        if (vecs[idx].write)
          wr_q.push_back(idx);
        else
          rd_q.push_back(idx);
        idx = idx + 1;
      end
      else
        req_valid = 1'b0;
    end
    step_cycle();
    req_valid = 1'b0;
    // drain, the watchdog catches a lost response or write strobe
    while (rd_q.size() != 0 || wr_q.size() != 0)
      step_cycle();
    repeat (4)
      step_cycle();
    check_credit("credits back when idle", credit_t'(QUEUE_DEPTH), credits);
    check_credit("credits used up", '0, min_credits);
    check_idle_pins("idle at end");
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/sram_model.sv ====
// behavioural asynchronous SRAM, 16K words of 32 bits
// each byte lane stores on the rising edge of its write enable
// read data only driven while chip select and output enable are low
// contents start unknown, read only what was written
`default_nettype none

module sram_model (
  input  smc_bus_pkg::addr_t   addr,
  input  smc_bus_pkg::data_t   wdata,
  output smc_bus_pkg::data_t   rdata,
  input  wire                  n_cs,
  input  wire                  n_oe,
  input  smc_mem_pkg::lane_t   n_we
);

  import smc_bus_pkg::*;
  import smc_mem_pkg::*;

  localparam int WORDS = 2 ** $bits(addr_t);

  // one byte array per lane
  logic [7:0] lane_mem [LANES][WORDS];

  // --------------------
  // write, end of pulse
  for (genvar i = 0; i < LANES; i++)
  begin : g_lane
    always @(posedge n_we[i])
    begin
      if (!n_cs)
        lane_mem[i][addr] <= wdata[8*i +: 8];
    end
  end

  // read path, unknown when not selected
  always_comb
  begin
    rdata = 'x;
    if (!n_cs && !n_oe)
      for (int i = 0; i < LANES; i++)
        rdata[8*i +: 8] = lane_mem[i][addr];
  end

endmodule

`default_nettype wire

// ==== verilog/smc_top.sv ====
// static memory controller, one 32-bit asynchronous SRAM bank
// requester must start with QUEUE_DEPTH credits after reset
// read responses cannot be stalled
`default_nettype none

module smc_top (
  input  wire                  hclk,
  input  wire                  arst_n,
  // requester side
  input  wire                  req_valid,
  input  wire                  req_write,
  input  smc_bus_pkg::addr_t   req_addr,
  input  smc_bus_pkg::data_t   req_wdata,
  input  smc_bus_pkg::be_t     req_be,
  output logic                 credit_return,
  output logic                 resp_valid,
  output smc_bus_pkg::data_t   resp_rdata,
  // sram pins
  output smc_bus_pkg::addr_t   mem_addr,
  output smc_bus_pkg::data_t   mem_wdata,
  input  smc_bus_pkg::data_t   mem_rdata,
  output logic                 mem_n_cs,
  output logic                 mem_n_oe,
  output smc_mem_pkg::lane_t   mem_n_we,
  output logic                 mem_n_wr
);

  import smc_bus_pkg::*;
  import smc_mem_pkg::*;

  req_t  req_in;
  logic  r_full;
  lane_t n_r_we;
  logic  n_r_wr;

  smc_req_if req_link ();

  // flat ports into one request word
  assign req_in = '{write: req_write, addr: req_addr, data: req_wdata, be: req_be};

  // --------------------
  smc_req_queue u_queue (
    .hclk          (hclk),
    .arst_n        (arst_n),
    .req_valid     (req_valid),
    .req_in        (req_in),
    .credit_return (credit_return),
    .deq           (req_link.src)
  );

  smc_access_ctrl u_ctrl (
    .hclk       (hclk),
    .arst_n     (arst_n),
    .req        (req_link.dst),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_rdata  (mem_rdata),
    .mem_n_cs   (mem_n_cs),
    .mem_n_oe   (mem_n_oe),
    .r_full     (r_full),
    .n_r_we     (n_r_we),
    .n_r_wr     (n_r_wr),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata)
  );

  // write strobes leave on the falling edge
  smc_wr_enable u_wr_enable (
    .hclk     (hclk),
    .arst_n   (arst_n),
    .r_full   (r_full),
    .n_r_we   (n_r_we),
    .n_r_wr   (n_r_wr),
    .smc_n_we (mem_n_we),
    .smc_n_wr (mem_n_wr)
  );

endmodule

`default_nettype wire

// ==== verilog/smc_wr_enable.sv ====
// gates per-lane write enables and the write strobe with the
// strobe window, then retimes them onto the falling clock edge
// pins settle half a cycle after r_full, inside address validity
`default_nettype none

module smc_wr_enable (
  input  wire                  hclk,
  input  wire                  arst_n,
  input  wire                  r_full,
  input  smc_mem_pkg::lane_t   n_r_we,
  input  wire                  n_r_wr,
  output smc_mem_pkg::lane_t   smc_n_we,
  output logic                 smc_n_wr
);

  import smc_mem_pkg::*;

  lane_t n_we_gated;
  logic  n_wr_gated;

  // --------------------
  // strobe gating
  // --------------------
  // lane low only with window open and lane requested
  assign n_we_gated = n_r_we | {LANES{~r_full}};
  assign n_wr_gated = n_r_wr | ~r_full;

  // falling edge retiming, inactive high out of reset
  always_ff @(negedge hclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      smc_n_we <= '1;
      smc_n_wr <= 1'b1;
    end
    else
    begin
      smc_n_we <= n_we_gated;
      smc_n_wr <= n_wr_gated;
    end
  end

  // closed window at a rising edge keeps every strobe high
  // from the following falling edge on
  a_we_in_window: assert property (
    @(negedge hclk) disable iff (!arst_n)
    !r_full |=> (&smc_n_we) && smc_n_wr
  );

endmodule

`default_nettype wire

// ==== verilog/smc_access_ctrl.sv ====
// access FSM for one asynchronous SRAM bank
// idle, setup, strobe, hold, then at least one idle cycle
// read data sampled on the edge that ends the strobe phase
// all pin-side controls are registered on the rising edge
`default_nettype none

module smc_access_ctrl (
  input  wire                  hclk,
  input  wire                  arst_n,
  smc_req_if.dst               req,
  output smc_bus_pkg::addr_t   mem_addr,
  output smc_bus_pkg::data_t   mem_wdata,
  input  smc_bus_pkg::data_t   mem_rdata,
  output logic                 mem_n_cs,
  output logic                 mem_n_oe,
  output logic                 r_full,
  output smc_mem_pkg::lane_t   n_r_we,
  output logic                 n_r_wr,
  output logic                 resp_valid,
  output smc_bus_pkg::data_t   resp_rdata
);

  import smc_bus_pkg::*;
  import smc_mem_pkg::*;

  enum logic [1:0] {S_IDLE, S_SETUP, S_STROBE, S_HOLD} state_q, state_d;

  logic [PHASE_W-1:0] cnt_q;
  logic [PHASE_W-1:0] cnt_d;
  logic               phase_done;
  logic               take;
  // direction of the access in flight
  logic               wr_q;
  logic               wr_d;

  assign phase_done = (cnt_q == '0);
  assign req.take   = take;
  assign wr_d       = take ? req.req.write : wr_q;

  // --------------------
  // next state
  // --------------------
  always_comb
  begin
    state_d = state_q;
    cnt_d   = cnt_q - 1'b1;
    take    = 1'b0;
    case (state_q)
      S_IDLE:
      begin
        cnt_d = cnt_q;
        // start as soon as the queue has a head
        if (req.valid)
        begin
          take    = 1'b1;
          state_d = S_SETUP;
          cnt_d   = PHASE_W'(SETUP_CYC - 1);
        end
      end
      S_SETUP:
        if (phase_done)
        begin
          state_d = S_STROBE;
          cnt_d   = PHASE_W'(STROBE_CYC - 1);
        end
      S_STROBE:
        if (phase_done)
        begin
          state_d = S_HOLD;
          cnt_d   = PHASE_W'(HOLD_CYC - 1);
        end
      default:
        if (phase_done)
        begin
          state_d = S_IDLE;
          cnt_d   = '0;
        end
    endcase
  end

  // --------------------
  // state and pin controls
  // --------------------
  always_ff @(posedge hclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q    <= S_IDLE;
      cnt_q      <= '0;
      wr_q       <= 1'b0;
      mem_n_cs   <= 1'b1;
      mem_n_oe   <= 1'b1;
      r_full     <= 1'b0;
      n_r_we     <= '1;
      n_r_wr     <= 1'b1;
      resp_valid <= 1'b0;
    end
    else
    begin
      state_q  <= state_d;
      cnt_q    <= cnt_d;
      wr_q     <= wr_d;
      // chip select spans setup through hold
      mem_n_cs <= (state_d == S_IDLE);
      // reads drive the bus until strobe ends
      mem_n_oe <= !(!wr_d && (state_d == S_SETUP || state_d == S_STROBE));
      // strobe window, writes only
      r_full   <= wr_d && (state_d == S_STROBE);
      if (take)
      begin
        n_r_we <= req.req.write ? ~req.req.be : '1;
        n_r_wr <= !req.req.write;
      end
      else if (state_d == S_IDLE)
      begin
        n_r_we <= '1;
        n_r_wr <= 1'b1;
      end
      // one response per read, end of strobe
      resp_valid <= !wr_q && (state_q == S_STROBE) && phase_done;
    end
  end

  // address, write data and read data have no reset
  always_ff @(posedge hclk)
  begin
    if (take)
    begin
      mem_addr  <= req.req.addr;
      mem_wdata <= req.req.data;
    end
    if (!wr_q && (state_q == S_STROBE) && phase_done)
      resp_rdata <= mem_rdata;
  end

  // take only from idle and only against a valid head
  a_take_idle: assert property (
    @(posedge hclk) disable iff (!arst_n)
    req.take |-> (state_q == S_IDLE) && req.valid
  );

  // queue head holds still until it is taken
  a_head_stable: assert property (
    @(posedge hclk) disable iff (!arst_n)
    req.valid && !req.take |=> req.valid && $stable(req.req)
  );

endmodule

`default_nettype wire

// ==== verilog/smc_req_queue.sv ====
// request FIFO behind credit-based flow control
// QUEUE_DEPTH must be a power of two, pointers wrap freely
// a push is never refused, the requester must respect its credits
// one credit_return pulse one cycle after each dequeue
`default_nettype none

module smc_req_queue #(
  parameter int QUEUE_DEPTH = smc_bus_pkg::QUEUE_DEPTH
) (
  input  wire                 hclk,
  input  wire                 arst_n,
  input  wire                 req_valid,
  input  smc_bus_pkg::req_t   req_in,
  output logic                credit_return,
  smc_req_if.src              deq
);

  import smc_bus_pkg::*;

  // storage, no reset needed
  req_t mem_q [QUEUE_DEPTH];

  logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr_q;
  // one extra bit to tell full from empty
  logic [$clog2(QUEUE_DEPTH):0]   count_q;

  logic push;
  logic pop;
  logic full;

  assign push = req_valid;
  assign pop  = deq.take;
  assign full = (count_q == QUEUE_DEPTH);

  // head is visible the cycle after it was written
  assign deq.valid = (count_q != '0);
  assign deq.req   = mem_q[rd_ptr_q];

  // --------------------
  // pointers and fill level
  // --------------------
  always_ff @(posedge hclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      count_q       <= '0;
      credit_return <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // freed entry goes back as a credit
      credit_return <= pop;
    end
  end

  // payload write
  always_ff @(posedge hclk)
  begin
    if (push)
      mem_q[wr_ptr_q] <= req_in;
  end

  // requester sent more than its credits allow
  a_no_overflow: assert property (
    @(posedge hclk) disable iff (!arst_n)
    req_valid |-> !full
  );

endmodule

`default_nettype wire

// ==== verilog/smc_req_if.sv ====
// one queued request handed from the queue to access control
// take is only legal while valid is high, entry leaves at that edge
`default_nettype none

interface smc_req_if;

  import smc_bus_pkg::*;

  // head of queue present
  logic valid;
  // head entry, stable while valid
  req_t req;
  // access control consumes the head
  logic take;

  // --------------------
  // queue side
  modport src (
    output valid,
    output req,
    input  take
  );

  // access control side
  modport dst (
    input  valid,
    input  req,
    output take
  );

endinterface

`default_nettype wire

// ==== verilog/smc_mem_pkg.sv ====
// memory-side definitions for one asynchronous SRAM bank
// phase lengths are fixed here, there are no timing registers
// every phase length must be at least 1 and fit in PHASE_W bits
`default_nettype none

package smc_mem_pkg;

  // --------------------
  // access phases
  // --------------------
  // address setup before strobe
  localparam int SETUP_CYC  = 1;
  // strobe window open
  localparam int STROBE_CYC = 2;
  // address and data hold after strobe
  localparam int HOLD_CYC   = 1;
  localparam int ACCESS_CYC = SETUP_CYC + STROBE_CYC + HOLD_CYC;

  // phase counter width, counts down from length-1
  localparam int PHASE_W    = 2;

  // --------------------
  // sram pins
  // --------------------
  localparam int LANES      = 4;
  // active low per-lane write enables
  typedef logic [LANES-1:0] lane_t;

endpackage

`default_nettype wire

// ==== verilog/smc_bus_pkg.sv ====
// requester-side definitions for the static memory controller
// bank is word addressed, 16K words of 32 bits
// byte enable bit n covers data bits 8n+7..8n
`default_nettype none

package smc_bus_pkg;

  // --------------------
  // request payload
  // --------------------
  typedef logic [13:0] addr_t;
  typedef logic [31:0] data_t;
  // one bit per byte lane
  typedef logic [3:0]  be_t;

  // 51 bits, write flag on top
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t data;
    be_t   be;
  } req_t;

  // --------------------
  // flow control
  // --------------------
  // queue entries and initial requester credits
  localparam int QUEUE_DEPTH = 4;
  // wide enough to hold QUEUE_DEPTH
  localparam int CREDIT_W    = 3;

endpackage

`default_nettype wire
